//--- rtl/line_draw_pkg.sv
`default_nettype none

package line_draw_pkg;

    // display is 320x240, 3-bit colour
    typedef logic [8:0]  coord_x_t;
    typedef logic [7:0]  coord_y_t;
    typedef logic [2:0]  color_t;

    // slave port
    typedef logic [2:0]  reg_addr_t;
    typedef logic [31:0] bus_data_t;

    // signed room for deltas and the doubled error term
    typedef logic signed [11:0] err_t;

    // register map, 6 and 7 unused
    localparam reg_addr_t ADDR_MODE       = 3'd0;
    localparam reg_addr_t ADDR_STATUS     = 3'd1;
    localparam reg_addr_t ADDR_GO         = 3'd2;
    localparam reg_addr_t ADDR_LINE_START = 3'd3;
    localparam reg_addr_t ADDR_LINE_END   = 3'd4;
    localparam reg_addr_t ADDR_LINE_COLOR = 3'd5;

    // endpoint word layout
    localparam int X_LSB = 0;
    localparam int X_MSB = 8;
    localparam int Y_LSB = 9;
    localparam int Y_MSB = 16;

    // mode register bit 0
    typedef enum logic {
        MODE_STALL = 1'b0,
        MODE_POLL  = 1'b1
    } draw_mode_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } point_t;

    // what the stepper latches on start
    typedef struct packed {
        point_t start_pt;
        point_t end_pt;
        color_t color;
    } line_cmd_t;

    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
        color_t   color;
    } pixel_t;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        STEP
    } stepper_state_t;

endpackage

`default_nettype wire

//--- rtl/line_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module line_reg_file import line_draw_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // slave port
    input  reg_addr_t i_address,
    input  logic      i_read,
    input  logic      i_write,
    input  bus_data_t i_writedata,
    output bus_data_t o_readdata,
    output logic      o_waitrequest,

    // stepper side
    input  logic      i_done,
    output logic      o_start,
    output line_cmd_t o_cmd
);

    // register contents
    draw_mode_t mode_q;
    point_t     start_q;
    point_t     end_q;
    color_t     color_q;

    // go edge detect and line tracking
    logic go_wr;
    logic go_q;
    logic go_accept;
    logic busy;

    // addressed word before the read gate
    bus_data_t rd_word;

    // pull x and y out of an endpoint word, upper bits dropped
    function automatic point_t unpack_point(input bus_data_t word);
        point_t p;
        p.x = word[X_MSB:X_LSB];
        p.y = word[Y_MSB:Y_LSB];
        return p;
    endfunction

    // inverse of the above, zeros above bit 16
    function automatic bus_data_t pack_point(input point_t p);
        bus_data_t word;
        word = '0;
        word[X_MSB:X_LSB] = p.x;
        word[Y_MSB:Y_LSB] = p.y;
        return word;
    endfunction

    assign go_wr = i_write && (i_address == ADDR_GO);

    // only the first cycle of a go write counts
    // and never while a line is in flight
    assign go_accept = go_wr && !go_q && !busy;

    // host registers, masked on write
    always_ff @(posedge clk) begin
        if (reset) begin
            mode_q  <= MODE_STALL;
            start_q <= '0;
            end_q   <= '0;
            color_q <= '0;
        end else if (i_write) begin
            case (i_address)
                ADDR_MODE:       mode_q  <= draw_mode_t'(i_writedata[0]);
                ADDR_LINE_START: start_q <= unpack_point(i_writedata);
                ADDR_LINE_END:   end_q   <= unpack_point(i_writedata);
                ADDR_LINE_COLOR: color_q <= i_writedata[$bits(color_t)-1:0];
                default: begin
                end
            endcase
        end
    end

    // go history, start pulse one cycle after the go
    always_ff @(posedge clk) begin
        if (reset) begin
            go_q    <= 1'b0;
            o_start <= 1'b0;
        end else begin
            go_q    <= go_wr;
            o_start <= go_accept;
        end
    end

    // busy from accepted go through the done cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (go_accept) begin
            busy <= 1'b1;
        end else if (i_done) begin
            busy <= 1'b0;
        end
    end

    // read mux
    always_comb begin
        case (i_address)
            ADDR_MODE:       rd_word = bus_data_t'(mode_q);
            ADDR_STATUS:     rd_word = bus_data_t'(busy);
            ADDR_GO:         rd_word = bus_data_t'(go_q);
            ADDR_LINE_START: rd_word = pack_point(start_q);
            ADDR_LINE_END:   rd_word = pack_point(end_q);
            ADDR_LINE_COLOR: rd_word = bus_data_t'(color_q);
            default:         rd_word = '0;
        endcase
    end

    // bus idles at zero between reads
    assign o_readdata = i_read ? rd_word : '0;

    // stall mode holds the host from the go until done
    assign o_waitrequest = (mode_q == MODE_STALL) && (busy || go_accept);

    // live register view, stepper samples it on start
    assign o_cmd.start_pt = start_q;
    assign o_cmd.end_pt   = end_q;
    assign o_cmd.color    = color_q;

endmodule

`default_nettype wire

//--- rtl/bresenham_stepper.sv
`timescale 1ns/1ps
`default_nettype none

module bresenham_stepper import line_draw_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      i_start,
    input  line_cmd_t i_cmd,
    output logic      o_pixel_valid,
    output pixel_t    o_pixel,
    output logic      o_done
);

    stepper_state_t state;
    stepper_state_t state_next;

    // command held for the whole line
    line_cmd_t cmd_q;

    // walking point and error bookkeeping
    point_t cur;
    err_t   dx;
    err_t   dy;
    err_t   err;
    logic   x_inc;
    logic   y_inc;

    // setup values from the latched command
    err_t   dx_calc;
    err_t   dy_calc;
    logic   x_inc_calc;
    logic   y_inc_calc;

    // per-step decisions
    err_t   e2;
    err_t   err_next;
    logic   step_x;
    logic   step_y;
    logic   at_end;

    // absolute deltas and step directions
    always_comb begin
        x_inc_calc = (cmd_q.end_pt.x >= cmd_q.start_pt.x);
        y_inc_calc = (cmd_q.end_pt.y >= cmd_q.start_pt.y);
        if (x_inc_calc) begin
            dx_calc = err_t'(cmd_q.end_pt.x - cmd_q.start_pt.x);
        end else begin
            dx_calc = err_t'(cmd_q.start_pt.x - cmd_q.end_pt.x);
        end
        if (y_inc_calc) begin
            dy_calc = err_t'(cmd_q.end_pt.y - cmd_q.start_pt.y);
        end else begin
            dy_calc = err_t'(cmd_q.start_pt.y - cmd_q.end_pt.y);
        end
    end

    // doubled error against -dy moves x, against dx moves y
    assign e2     = err <<< 1;
    assign step_x = (e2 > -dy);
    assign step_y = (e2 < dx);
    assign at_end = (cur == cmd_q.end_pt);

    // both corrections can apply in one step (diagonal move)
    always_comb begin
        err_next = err;
        if (step_x) begin
            err_next = err_next - dy;
        end
        if (step_y) begin
            err_next = err_next + dx;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (i_start) begin
                    state_next = SETUP;
                end
            end
            SETUP: begin
                state_next = STEP;
            end
            STEP: begin
                // last pixel goes out this cycle
                if (at_end) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (i_start) begin
                    cmd_q <= i_cmd;
                end
            end
            SETUP: begin
                dx    <= dx_calc;
                dy    <= dy_calc;
                x_inc <= x_inc_calc;
                y_inc <= y_inc_calc;
                // initial error is dx - dy
                err   <= dx_calc - dy_calc;
                cur   <= cmd_q.start_pt;
            end
            STEP: begin
                if (!at_end) begin
                    if (step_x) begin
                        cur.x <= x_inc ? cur.x + coord_x_t'(1) : cur.x - coord_x_t'(1);
                    end
                    if (step_y) begin
                        cur.y <= y_inc ? cur.y + coord_y_t'(1) : cur.y - coord_y_t'(1);
                    end
                    err <= err_next;
                end
            end
            default: begin
            end
        endcase
    end

    // one pixel per STEP cycle, done with the end point
    assign o_pixel_valid = (state == STEP);
    assign o_done        = (state == STEP) && at_end;

    always_comb begin
        o_pixel.x     = cur.x;
        o_pixel.y     = cur.y;
        o_pixel.color = cmd_q.color;
    end

endmodule

`default_nettype wire

//--- rtl/line_draw_accel.sv
`timescale 1ns/1ps
`default_nettype none

module line_draw_accel import line_draw_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    // host slave port
    input  reg_addr_t i_address,
    input  logic      i_read,
    input  logic      i_write,
    input  bus_data_t i_writedata,
    output bus_data_t o_readdata,
    output logic      o_waitrequest,

    // pixel strobe to the framebuffer writer
    output logic      o_pixel_valid,
    output pixel_t    o_pixel,
    output logic      o_line_done
);

    // register file to stepper
    logic      line_start;
    line_cmd_t line_cmd;
    // done pulse goes back to regs and out
    logic      line_done;

    line_reg_file regs0 (
        .clk           (clk),
        .reset         (reset),
        .i_address     (i_address),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_writedata   (i_writedata),
        .o_readdata    (o_readdata),
        .o_waitrequest (o_waitrequest),
        .i_done        (line_done),
        .o_start       (line_start),
        .o_cmd         (line_cmd)
    );

    bresenham_stepper step0 (
        .clk           (clk),
        .reset         (reset),
        .i_start       (line_start),
        .i_cmd         (line_cmd),
        .o_pixel_valid (o_pixel_valid),
        .o_pixel       (o_pixel),
        .o_done        (line_done)
    );

    assign o_line_done = line_done;

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 8 ns period
    localparam int HALF_PERIOD_NS = 4;
    localparam int RESET_CYCLES   = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS);
            clk = ~clk;
        end
    end

    // released on a falling edge like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/line_draw_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module line_draw_accel_tb import line_draw_pkg::*; ();

    localparam int NUM_POLL     = 40;
    localparam int NUM_STALL    = 8;
    // upper bound on lines drawn over all groups
    localparam int NUM_LINES    = 64;
    // longest line plus register writes and latency
    localparam int MAX_LINE_CYC = 340;
    localparam int CLK_NS       = 8;
    localparam int WATCHDOG_NS  = NUM_LINES * MAX_LINE_CYC * CLK_NS + 20000;

    logic      clk;
    logic      reset;
    reg_addr_t i_address;
    logic      i_read;
    logic      i_write;
    bus_data_t i_writedata;
    bus_data_t o_readdata;
    logic      o_waitrequest;
    logic      o_pixel_valid;
    pixel_t    o_pixel;
    logic      o_line_done;

    // capture of every pixel and done pulse with cycle labels
    int     cyc;
    pixel_t pix_q[$];
    int     pix_cyc_q[$];
    int     done_cyc_q[$];

    // reference pixel list for the current line
    int exp_x[$];
    int exp_y[$];

    bit [31:0] rng_state;
    int        errors;
    int        tests_ok;
    int        tests_bad;

    tb_clock_gen clkgen0 (
        .clk   (clk),
        .reset (reset)
    );

    line_draw_accel dut0 (
        .clk           (clk),
        .reset         (reset),
        .i_address     (i_address),
        .i_read        (i_read),
        .i_write       (i_write),
        .i_writedata   (i_writedata),
        .o_readdata    (o_readdata),
        .o_waitrequest (o_waitrequest),
        .o_pixel_valid (o_pixel_valid),
        .o_pixel       (o_pixel),
        .o_line_done   (o_line_done)
    );

    // sampled on the rising edge and labelled with the cycle that just ended
    always @(posedge clk) begin
        if (reset) begin
            cyc = 0;
        end else begin
            if (o_pixel_valid) begin
                pix_q.push_back(o_pixel);
                pix_cyc_q.push_back(cyc);
            end
            if (o_line_done) begin
                done_cyc_q.push_back(cyc);
            end
            cyc = cyc + 1;
        end
    end

    // hard stop if a line never finishes
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the lines did not all finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    function automatic int next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[30:8]);
    endfunction

    task automatic check_val(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // one bus cycle from falling edge to falling edge with strobes idle after
    task automatic bus_cycle(input logic rd, input logic wr, input reg_addr_t addr,
                             input bus_data_t data, output bus_data_t rdata);
        i_read      = rd;
        i_write     = wr;
        i_address   = addr;
        i_writedata = data;
        @(posedge clk);
        rdata = o_readdata;
        @(negedge clk);
        i_read  = 1'b0;
        i_write = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input bus_data_t data);
        bus_data_t unused;
        bus_cycle(1'b0, 1'b1, addr, data, unused);
    endtask

    task automatic read_check(input reg_addr_t addr, input int exp, input string what);
        bus_data_t rdata;
        bus_cycle(1'b1, 1'b0, addr, '0, rdata);
        check_val(what, int'(rdata), exp);
    endtask

    // integer bresenham with the error starting at dx - dy
    task automatic build_model(input int sx, input int sy, input int ex, input int ey);
        int x;
        int y;
        int dx;
        int dy;
        int stx;
        int sty;
        int err;
        int e2;
        x   = sx;
        y   = sy;
        dx  = (ex >= sx) ? ex - sx : sx - ex;
        dy  = (ey >= sy) ? ey - sy : sy - ey;
        stx = (ex >= sx) ? 1 : -1;
        sty = (ey >= sy) ? 1 : -1;
        err = dx - dy;
        exp_x.delete();
        exp_y.delete();
        exp_x.push_back(x);
        exp_y.push_back(y);
        while (x != ex || y != ey) begin
            e2 = 2 * err;
            if (e2 > -dy) begin
                err = err - dy;
                x   = x + stx;
            end
            if (e2 < dx) begin
                err = err + dx;
                y   = y + sty;
            end
            exp_x.push_back(x);
            exp_y.push_back(y);
        end
    endtask

    // endpoint and colour writes carry junk above the fields
    task automatic set_line(input int sx, input int sy, input int ex, input int ey,
                            input int col);
        bus_data_t word;
        word = (bus_data_t'(next_rand()) << 17) | (bus_data_t'(sy) << 9) | bus_data_t'(sx);
        write_reg(ADDR_LINE_START, word);
        word = (bus_data_t'(next_rand()) << 17) | (bus_data_t'(ey) << 9) | bus_data_t'(ex);
        write_reg(ADDR_LINE_END, word);
        word = (bus_data_t'(next_rand()) << 3) | bus_data_t'(col);
        write_reg(ADDR_LINE_COLOR, word);
        build_model(sx, sy, ex, ey);
    endtask

    // pixels since pbase against the model including latency and gaps
    task automatic check_line(input int go_cyc, input int col, input int pbase,
                              input int dbase);
        int n;
        int got_n;
        int i;
        n     = exp_x.size();
        got_n = pix_q.size() - pbase;
        check_val("pixel count", got_n, n);
        check_val("done pulses", done_cyc_q.size() - dbase, 1);
        for (i = 0; i < n && i < got_n; i++) begin
            check_val("pixel x", int'(pix_q[pbase + i].x), exp_x[i]);
            check_val("pixel y", int'(pix_q[pbase + i].y), exp_y[i]);
            check_val("pixel colour", int'(pix_q[pbase + i].color), col);
            // first pixel 3 cycles after go and then back to back
            check_val("pixel cycle", pix_cyc_q[pbase + i], go_cyc + 3 + i);
        end
        // done rides on the last pixel
        if (done_cyc_q.size() > dbase) begin
            check_val("done cycle", done_cyc_q[dbase], go_cyc + 2 + n);
        end
    endtask

    // poll mode with status read every cycle until well past done
    task automatic draw_poll(input int sx, input int sy, input int ex, input int ey,
                             input int col, input bit second_go);
        int        go_cyc;
        int        n;
        int        c;
        int        pbase;
        int        dbase;
        bus_data_t rdata;
        set_line(sx, sy, ex, ey, col);
        n      = exp_x.size();
        pbase  = pix_q.size();
        dbase  = done_cyc_q.size();
        go_cyc = cyc;
        write_reg(ADDR_GO, 32'd1);
        for (c = go_cyc + 1; c <= go_cyc + n + 4; c++) begin
            if (second_go && c == go_cyc + n + 2) begin
                // fresh go edge in the done cycle must be dropped
                write_reg(ADDR_GO, 32'd1);
            end else begin
                bus_cycle(1'b1, 1'b0, ADDR_STATUS, '0, rdata);
                check_val("status", int'(rdata), (c <= go_cyc + n + 2) ? 1 : 0);
            end
        end
        check_line(go_cyc, col, pbase, dbase);
    endtask

    // stall mode with the go write held while wait-request is up
    task automatic draw_stall(input int sx, input int sy, input int ex, input int ey,
                              input int col);
        int go_cyc;
        int n;
        int pbase;
        int dbase;
        int wait_cyc;
        int stall_pix;
        bit waiting;
        set_line(sx, sy, ex, ey, col);
        n           = exp_x.size();
        pbase       = pix_q.size();
        dbase       = done_cyc_q.size();
        go_cyc      = cyc;
        wait_cyc    = 0;
        stall_pix   = 0;
        waiting     = 1'b1;
        i_address   = ADDR_GO;
        i_writedata = 32'd1;
        i_write     = 1'b1;
        while (waiting) begin
            @(posedge clk);
            if (o_waitrequest) begin
                wait_cyc++;
                if (o_pixel_valid) begin
                    stall_pix++;
                end
            end else begin
                waiting = 1'b0;
            end
        end
        @(negedge clk);
        i_write = 1'b0;
        // go cycle, setup latency and every pixel
        check_val("stall cycles", wait_cyc, n + 3);
        check_val("pixels under stall", stall_pix, n);
        check_line(go_cyc, col, pbase, dbase);
    endtask

    task automatic readback_test();
        bus_data_t d;
        int        a;
        for (a = 0; a < 8; a++) begin
            read_check(reg_addr_t'(a), 0, "reset value");
        end
        repeat (6) begin
            d = (bus_data_t'(next_rand()) << 16) ^ bus_data_t'(next_rand());
            write_reg(ADDR_MODE, d);
            read_check(ADDR_MODE, int'(d & 32'h1), "mode readback");
            write_reg(ADDR_LINE_START, d);
            read_check(ADDR_LINE_START, int'(d & 32'h1FFFF), "start readback");
            write_reg(ADDR_LINE_END, ~d);
            read_check(ADDR_LINE_END, int'(~d & 32'h1FFFF), "end readback");
            write_reg(ADDR_LINE_COLOR, d);
            read_check(ADDR_LINE_COLOR, int'(d & 32'h7), "colour readback");
            write_reg(3'd6, d);
            read_check(3'd6, 0, "address 6");
            read_check(3'd7, 0, "address 7");
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %s: ok", name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", name, errors - err_before);
            tests_bad++;
        end
    endtask

    initial begin
        int        err0;
        int        k;
        int        sx;
        int        sy;
        int        ex;
        int        ey;
        int        col;
        int        go_cyc;
        int        pbase;
        int        dbase;
        i_address   = '0;
        i_read      = 1'b0;
        i_write     = 1'b0;
        i_writedata = '0;
        rng_state   = 32'd4582;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        @(negedge reset);
        @(negedge clk);

        err0 = errors;
        readback_test();
        finish_test("register_readback", err0);

        // poll mode where every fourth line gets a go while busy
        write_reg(ADDR_MODE, 32'd1);
        err0 = errors;
        for (k = 0; k < NUM_POLL; k++) begin
            sx  = next_rand() % 320;
            sy  = next_rand() % 240;
            ex  = next_rand() % 320;
            ey  = next_rand() % 240;
            col = next_rand() % 8;
            draw_poll(sx, sy, ex, ey, col, (k % 4) == 1);
        end
        finish_test("poll_lines", err0);

        err0 = errors;
        // single point, flat, vertical, steep down, corners
        draw_poll(5, 7, 5, 7, 3, 1'b0);
        draw_poll(0, 120, 319, 120, 1, 1'b0);
        draw_poll(319, 60, 0, 60, 6, 1'b0);
        draw_poll(160, 239, 160, 0, 2, 1'b1);
        draw_poll(10, 230, 40, 3, 5, 1'b0);
        draw_poll(0, 0, 319, 239, 7, 1'b0);
        draw_poll(319, 0, 0, 239, 4, 1'b0);
        finish_test("edge_lines", err0);

        // go held over two cycles starts one line only
        err0 = errors;
        set_line(20, 200, 90, 150, 5);
        pbase  = pix_q.size();
        dbase  = done_cyc_q.size();
        go_cyc = cyc;
        write_reg(ADDR_GO, 32'd1);
        write_reg(ADDR_GO, 32'd1);
        repeat (exp_x.size() + 4) @(negedge clk);
        check_line(go_cyc, 5, pbase, dbase);
        finish_test("held_go", err0);

        write_reg(ADDR_MODE, 32'd0);
        err0 = errors;
        for (k = 0; k < NUM_STALL; k++) begin
            sx  = next_rand() % 320;
            sy  = next_rand() % 240;
            ex  = next_rand() % 320;
            ey  = next_rand() % 240;
            col = next_rand() % 8;
            draw_stall(sx, sy, ex, ey, col);
        end
        finish_test("stall_lines", err0);

        $display("tests ok %0d, tests with errors %0d, total errors %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
rtl/line_draw_pkg.sv
rtl/line_reg_file.sv
rtl/bresenham_stepper.sv
rtl/line_draw_accel.sv
sim/tb_clock_gen.sv
sim/line_draw_accel_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the line draw testbench with Verilator, run it, scan the log

TOP=line_draw_accel_tb
OBJ_DIR=obj_dir
LOG=sim.log

# everything is relative to the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    --top-module "$TOP" \
    -Mdir "$OBJ_DIR" \
    -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the verdict
if grep -q "Test failed" "$LOG"; then
    echo "fail message found in $LOG"
    exit 1
fi

echo "no failure reported in $LOG"
exit 0
